// ==== src.f ====
src/calc_pkg.sv
src/seq_multiplier.sv
src/sm_adder.sv
src/calc_control.sv
src/calculator_top.sv
verif/calculator_chk.sv
verif/calculator_tb.sv

// ==== src/calc_control.sv ====
// calc_control: keypad entry and operation sequencing FSM for the calculator
`default_nettype none

module calc_control import calc_pkg::*; #(
    parameter int WIDTH = CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       keypad,
    input  logic             read_input,
    input  calc_op_t         operator_input,
    input  logic             equal_input,
    output logic [WIDTH-1:0] mul_a,
    output logic [WIDTH-1:0] mul_b,
    output logic [WIDTH-1:0] add_a,
    output logic [WIDTH-1:0] add_b,
    output logic             mul_start,
    output logic             add_sub,
    output logic             add_start,
    input  logic [WIDTH-1:0] mul_result,
    input  logic [WIDTH-1:0] add_result,
    input  logic             mul_finish,
    input  logic             add_finish,
    output logic             complete,
    output logic [WIDTH-1:0] display_output
);

    localparam int MAG = WIDTH - 1;
    localparam logic [WIDTH-1:0] TEN = WIDTH'(10);

    calc_state_t    state;
    calc_state_t    next_state;
    calc_op_t       op;
    logic [WIDTH-1:0] operand1;
    logic [WIDTH-1:0] operand2;
    logic [3:0]     digit;
    logic [MAG-1:0] digit_ext;

    logic           in_op1;
    logic           in_op2;
    logic           entry_open;
    logic           digit_take;
    logic           sign_toggle;
    logic           op_arith;
    logic [WIDTH-1:0] entry_operand;

    assign in_op1 = (state == ENTER_OP1);
    assign in_op2 = (state == ENTER_OP2);

    // equal has priority over a key in the second operand
    assign entry_open = in_op1 || (in_op2 && !equal_input);
    assign digit_take = read_input && entry_open;

    // a digit wins over a sign toggle in the same cycle
    assign sign_toggle = (operator_input == OP_NEG) && !read_input && entry_open;

    assign op_arith = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    assign entry_operand = in_op2 ? operand2 : operand1;
    assign digit_ext     = {{(MAG - 4){1'b0}}, digit};

    // next state
    always_comb begin
        next_state = state;
        case (state)
            ENTER_OP1: begin
                if (read_input)
                    next_state = WAIT_SHIFT1;
                else if (op_arith)
                    next_state = ENTER_OP2;
            end
            WAIT_SHIFT1: begin
                if (mul_finish)
                    next_state = ADD_DIGIT1;
            end
            ADD_DIGIT1:
                next_state = ENTER_OP1;
            ENTER_OP2: begin
                if (equal_input)
                    next_state = LAUNCH;
                else if (read_input)
                    next_state = WAIT_SHIFT2;
            end
            WAIT_SHIFT2: begin
                if (mul_finish)
                    next_state = ADD_DIGIT2;
            end
            ADD_DIGIT2:
                next_state = ENTER_OP2;
            LAUNCH:
                next_state = WAIT_RESULT;
            WAIT_RESULT: begin
                // only the unit that was started can finish
                if (op == OP_MUL) begin
                    if (mul_finish)
                        next_state = SHOW_MUL;
                end else if (add_finish) begin
                    next_state = SHOW_ADD;
                end
            end
            SHOW_ADD, SHOW_MUL:
                next_state = ENTER_OP1;
            default:
                next_state = ENTER_OP1;
        endcase
    end

    // state, operands and strobes
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_OP1;
            op             <= OP_NONE;
            operand1       <= '0;
            operand2       <= '0;
            mul_start      <= 1'b0;
            add_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            mul_start <= digit_take || (state == LAUNCH && op == OP_MUL);
            add_start <= (state == LAUNCH) && (op != OP_MUL);
            complete  <= 1'b0;

            case (state)
                ENTER_OP1: begin
                    if (sign_toggle)
                        operand1[WIDTH-1] <= ~operand1[WIDTH-1];
                    else if (!read_input && op_arith)
                        op <= operator_input;
                end
                WAIT_SHIFT1: begin
                    // keep the entered sign, a zero product would lose it
                    if (mul_finish)
                        operand1 <= {operand1[WIDTH-1], mul_result[MAG-1:0]};
                end
                ADD_DIGIT1:
                    operand1[MAG-1:0] <= operand1[MAG-1:0] + digit_ext;
                ENTER_OP2: begin
                    if (sign_toggle)
                        operand2[WIDTH-1] <= ~operand2[WIDTH-1];
                end
                WAIT_SHIFT2: begin
                    if (mul_finish)
                        operand2 <= {operand2[WIDTH-1], mul_result[MAG-1:0]};
                end
                ADD_DIGIT2:
                    operand2[MAG-1:0] <= operand2[MAG-1:0] + digit_ext;
                SHOW_ADD, SHOW_MUL: begin
                    display_output <= (state == SHOW_MUL) ? mul_result : add_result;
                    complete       <= 1'b1;
                    // no chaining, next entry starts from plus zero
                    operand1       <= '0;
                    operand2       <= '0;
                    op             <= OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // operands for the arithmetic units, loaded with their start
    always_ff @(posedge clk) begin
        if (digit_take) begin
            digit <= keypad;
            mul_a <= entry_operand;
            mul_b <= TEN;
        end else if (state == LAUNCH) begin
            mul_a   <= operand1;
            mul_b   <= operand2;
            add_a   <= operand1;
            add_b   <= operand2;
            add_sub <= (op == OP_SUB);
        end
    end

endmodule

`default_nettype wire

// ==== src/calc_pkg.sv ====
// calc_pkg: controller state enum, operator code enum, default data width
`default_nettype none

package calc_pkg;

    // default data width, top bit is the sign
    parameter int CALC_WIDTH = 16;

    // controller states
    typedef enum logic [3:0] {
        ENTER_OP1,
        // operand1 times ten in flight
        WAIT_SHIFT1,
        ADD_DIGIT1,
        ENTER_OP2,
        WAIT_SHIFT2,
        ADD_DIGIT2,
        // start the selected unit
        LAUNCH,
        WAIT_RESULT,
        SHOW_ADD,
        SHOW_MUL
    } calc_state_t;

    // keypad operator codes
    typedef enum logic [2:0] {
        // idle level between key presses
        OP_NONE = 3'd0,
        // toggle sign of operand being entered
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

endpackage

`default_nettype wire

// ==== src/calculator_top.sv ====
// calculator_top: controller with its multiplier and adder
`default_nettype none

module calculator_top import calc_pkg::*; #(
    parameter int WIDTH = CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       keypad,
    input  logic             read_input,
    input  calc_op_t         operator_input,
    input  logic             equal_input,
    output logic             complete,
    output logic [WIDTH-1:0] display_output
);

    logic [WIDTH-1:0] mul_a;
    logic [WIDTH-1:0] mul_b;
    logic [WIDTH-1:0] mul_result;
    logic             mul_start;
    logic             mul_finish;

    logic [WIDTH-1:0] add_a;
    logic [WIDTH-1:0] add_b;
    logic [WIDTH-1:0] add_result;
    logic             add_sub;
    logic             add_start;
    logic             add_finish;

    calc_control #(.WIDTH(WIDTH)) calc_control_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad         (keypad),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .add_a          (add_a),
        .add_b          (add_b),
        .mul_start      (mul_start),
        .add_sub        (add_sub),
        .add_start      (add_start),
        .mul_result     (mul_result),
        .add_result     (add_result),
        .mul_finish     (mul_finish),
        .add_finish     (add_finish),
        .complete       (complete),
        .display_output (display_output)
    );

    // shared by digit entry and multiply
    seq_multiplier #(.WIDTH(WIDTH)) seq_multiplier_i (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mul_a),
        .b      (mul_b),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

    sm_adder #(.WIDTH(WIDTH)) sm_adder_i (
        .clk    (clk),
        .nRST   (nRST),
        .a      (add_a),
        .b      (add_b),
        .sub    (add_sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

endmodule

`default_nettype wire

// ==== src/seq_multiplier.sv ====
// seq_multiplier: iterative shift-add sign-magnitude multiplier
`default_nettype none

module seq_multiplier import calc_pkg::*; #(
    parameter int WIDTH = CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             start,
    output logic [WIDTH-1:0] result,
    output logic             finish
);

    localparam int MAG = WIDTH - 1;
    localparam int CW  = $clog2(WIDTH);

    logic          busy;
    logic [CW-1:0] count;
    logic          sign;
    logic [MAG-1:0] a_shift;
    logic [MAG-1:0] b_shift;
    logic [MAG-1:0] acc;

    // one iteration per magnitude bit of b, finish on the last one
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CW'(MAG - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // partial product kept to magnitude width, so it wraps
    always_ff @(posedge clk) begin
        if (start) begin
            a_shift <= a[MAG-1:0];
            b_shift <= b[MAG-1:0];
            acc     <= '0;
            sign    <= a[WIDTH-1] ^ b[WIDTH-1];
        end else if (busy) begin
            if (b_shift[0])
                acc <= acc + a_shift;
            a_shift <= a_shift << 1;
            b_shift <= b_shift >> 1;
        end
    end

    // zero magnitude is always positive
    assign result = {sign & (acc != '0), acc};

endmodule

`default_nettype wire

// ==== src/sm_adder.sv ====
// sm_adder: registered sign-magnitude adder/subtractor
`default_nettype none

module sm_adder import calc_pkg::*; #(
    parameter int WIDTH = CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             sub,
    input  logic             start,
    output logic [WIDTH-1:0] result,
    output logic             finish
);

    localparam int MAG = WIDTH - 1;

    logic           a_sign;
    logic           b_sign;
    logic [MAG-1:0] a_mag;
    logic [MAG-1:0] b_mag;
    logic [MAG-1:0] mag_next;
    logic           sign_next;

    assign a_sign = a[WIDTH-1];
    // subtract is add with b negated
    assign b_sign = b[WIDTH-1] ^ sub;
    assign a_mag  = a[MAG-1:0];
    assign b_mag  = b[MAG-1:0];

    always_comb begin
        if (a_sign == b_sign) begin
            mag_next  = a_mag + b_mag;
            sign_next = a_sign;
        end else if (a_mag >= b_mag) begin
            mag_next  = a_mag - b_mag;
            sign_next = a_sign;
        end else begin
            mag_next  = b_mag - a_mag;
            sign_next = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            finish <= 1'b0;
        else
            finish <= start;
    end

    // equal magnitudes of opposite sign give plus zero
    always_ff @(posedge clk) begin
        if (start)
            result <= {sign_next & (mag_next != '0), mag_next};
    end

endmodule

`default_nettype wire

// ==== verif/calculator_chk.sv ====
// calculator_chk: concurrent assertions on the calculator controller
`default_nettype none

module calculator_chk import calc_pkg::*; #(
    parameter int WIDTH = CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             complete,
    input  logic             mul_start,
    input  logic             add_start,
    input  logic [WIDTH-1:0] display_output
);

    timeunit 1ns;
    timeprecision 100ps;

    // complete is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete stayed high for two cycles");

    // only one arithmetic unit is started at a time
    assert property (@(posedge clk) disable iff (!nRST)
        !(mul_start && add_start))
        else $error("mul_start and add_start high in the same cycle");

    // display only moves together with complete
    assert property (@(posedge clk) disable iff (!nRST)
        $changed(display_output) |-> complete)
        else $error("display_output changed without complete");

endmodule

`default_nettype wire

// ==== verif/calculator_tb.sv ====
// calculator_tb: clock, reset, random key sequences, reference model, checks and summary
`default_nettype none

module calculator_tb import calc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIDTH       = CALC_WIDTH;
    localparam int MAG         = WIDTH - 1;
    localparam int GAP         = WIDTH + 6;
    localparam int RESULT_WAIT = WIDTH + 10;
    localparam int MAX_DIGITS  = 8;
    localparam int K_ADDSUB    = 0;
    localparam int K_ZERO      = 1;
    localparam int K_MUL       = 2;
    localparam int K_OVERFLOW  = 3;
    localparam int K_STRAY     = 4;
    localparam int K_MIXED     = 5;
    localparam int TOTAL_OPS   = 12 + 4 + 12 + 6 + 6 + 10;
    // stray equal, two sign toggles, digits and operator, then equal and result wait
    localparam int OP_CYCLES   = (2 * MAX_DIGITS + 4) * GAP + RESULT_WAIT + 4;
    localparam int LIMIT       = TOTAL_OPS * OP_CYCLES + 200;

    logic             clk;
    logic             nRST;
    logic [3:0]       keypad;
    logic             read_input;
    calc_op_t         operator_input;
    logic             equal_input;
    logic             complete;
    logic [WIDTH-1:0] display_output;

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_count;

    calculator_top #(.WIDTH(WIDTH)) calculator_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad         (keypad),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    bind calc_control calculator_chk #(.WIDTH(WIDTH)) calculator_chk_i (
        .clk            (clk),
        .nRST           (nRST),
        .complete       (complete),
        .mul_start      (mul_start),
        .add_start      (add_start),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [WIDTH-1:0] expected,
                               input logic [WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // magnitude times ten plus digit, wrapped to the magnitude range
    function automatic logic [MAG-1:0] accumulate_digit(input logic [MAG-1:0] mag,
                                                        input logic [3:0] d);
        longint unsigned full;
        full = longint'(mag) * 10 + longint'(d);
        return MAG'(full % (64'd1 << MAG));
    endfunction

    // exact signed arithmetic, then back to sign-magnitude with plus zero
    function automatic logic [WIDTH-1:0] expected_result(input logic neg_a,
            input logic [MAG-1:0] mag_a, input logic neg_b, input logic [MAG-1:0] mag_b,
            input calc_op_t op);
        longint va;
        longint vb;
        longint r;
        longint unsigned r_abs;
        logic [MAG-1:0] mag;
        va = neg_a ? -longint'(mag_a) : longint'(mag_a);
        vb = neg_b ? -longint'(mag_b) : longint'(mag_b);
        case (op)
            OP_ADD:  r = va + vb;
            OP_SUB:  r = va - vb;
            default: r = va * vb;
        endcase
        r_abs = (r < 0) ? -r : r;
        mag = MAG'(r_abs % (64'd1 << MAG));
        return {(r < 0) && (mag != '0), mag};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic enter_digit(input logic [3:0] d);
        keypad     = d;
        read_input = 1'b1;
        idle_cycles(1);
        read_input = 1'b0;
        idle_cycles(GAP - 1);
    endtask

    task automatic send_operator(input calc_op_t op);
        operator_input = op;
        idle_cycles(1);
        operator_input = OP_NONE;
        idle_cycles(GAP - 1);
    endtask

    task automatic strobe_equal();
        equal_input = 1'b1;
        idle_cycles(1);
        equal_input = 1'b0;
    endtask

    task automatic run_operation(input calc_op_t op, input int n1, input int n2,
                                 input bit stray, input bit zero_pair);
        logic [MAG-1:0]   mag1;
        logic [MAG-1:0]   mag2;
        logic             neg1;
        logic             neg2;
        logic [3:0]       digits[$];
        logic [3:0]       d;
        logic [WIDTH-1:0] expected;
        int               flip1;
        int               flip2;
        int               i;
        int               waited;
        bit               got;
        mag1  = '0;
        mag2  = '0;
        neg1  = 1'($urandom_range(0, 1));
        flip1 = $urandom_range(0, n1);
        // equal before any operator must be ignored
        if (stray) begin
            strobe_equal();
            idle_cycles(GAP - 1);
        end
        for (i = 0; i <= n1; i++) begin
            if (neg1 && i == flip1)
                send_operator(OP_NEG);
            if (i < n1) begin
                d = 4'($urandom_range(0, 9));
                digits.push_back(d);
                enter_digit(d);
                mag1 = accumulate_digit(mag1, d);
            end
        end
        send_operator(op);
        // same digits with signs that cancel
        if (zero_pair)
            neg2 = (op == OP_SUB) ? neg1 : !neg1;
        else
            neg2 = 1'($urandom_range(0, 1));
        flip2 = $urandom_range(0, n2);
        for (i = 0; i <= n2; i++) begin
            if (neg2 && i == flip2)
                send_operator(OP_NEG);
            if (i < n2) begin
                d = zero_pair ? digits[i] : 4'($urandom_range(0, 9));
                enter_digit(d);
                mag2 = accumulate_digit(mag2, d);
            end
        end
        expected = expected_result(neg1, mag1, neg2, mag2, op);
        strobe_equal();
        waited = 0;
        got    = 1'b0;
        while (!got && waited < RESULT_WAIT) begin
            // read and equal during LAUNCH and WAIT_RESULT
            read_input  = stray && waited < 2;
            equal_input = stray && waited < 2;
            keypad      = 4'($urandom_range(0, 9));
            idle_cycles(1);
            waited++;
            got = complete;
        end
        read_input  = 1'b0;
        equal_input = 1'b0;
        if (got) begin
            check_value("display_output", expected, display_output);
        end else begin
            errors++;
            $display("no result arrived within %0d cycles of equal", RESULT_WAIT);
        end
        idle_cycles(2);
    endtask

    task automatic report_test(input string name, input int ops, input int start_errors);
        tests_run++;
        if (errors != start_errors)
            tests_failed++;
        $display("test %0d %s: %0d operations, %0d errors", tests_run, name, ops,
                 errors - start_errors);
    endtask

    task automatic check_reset_state();
        int start_errors;
        start_errors = errors;
        repeat (8) begin
            check_value("complete", '0, WIDTH'(complete));
            check_value("display_output", '0, display_output);
            idle_cycles(1);
        end
        report_test("reset", 0, start_errors);
    endtask

    task automatic run_group(input string name, input int kind, input int count);
        int       start_errors;
        int       k;
        int       n1;
        calc_op_t op;
        start_errors = errors;
        for (k = 0; k < count; k++) begin
            n1 = $urandom_range(1, 4);
            op = calc_op_t'(3'($urandom_range(2, 4)));
            case (kind)
                K_ADDSUB: begin
                    op = $urandom_range(0, 1) ? OP_SUB : OP_ADD;
                    run_operation(op, n1, $urandom_range(1, 4), 1'b0, 1'b0);
                end
                K_ZERO: begin
                    op = $urandom_range(0, 1) ? OP_SUB : OP_ADD;
                    run_operation(op, n1, n1, 1'b0, 1'b1);
                end
                K_MUL:
                    run_operation(OP_MUL, $urandom_range(1, 3), $urandom_range(1, 3),
                                  1'b0, 1'b0);
                K_OVERFLOW:
                    run_operation(op, $urandom_range(6, MAX_DIGITS),
                                  $urandom_range(6, MAX_DIGITS), 1'b0, 1'b0);
                K_STRAY:
                    run_operation(op, $urandom_range(1, 3), $urandom_range(1, 3),
                                  1'b1, 1'b0);
                default:
                    run_operation(op, n1, $urandom_range(1, 4), 1'b0, 1'b0);
            endcase
        end
        report_test(name, count, start_errors);
    endtask

    initial begin
        void'($urandom(32'ha36d_7727));
        nRST           = 1'b0;
        keypad         = 4'd0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        checks         = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (4) @(posedge clk);
        #1;
        nRST = 1'b1;
        check_reset_state();
        run_group("add_sub", K_ADDSUB, 12);
        run_group("plus_zero", K_ZERO, 4);
        run_group("multiply", K_MUL, 12);
        run_group("overflow", K_OVERFLOW, 6);
        run_group("ignored_strobes", K_STRAY, 6);
        run_group("back_to_back", K_MIXED, 10);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // run limit from the longest operation times the number of operations
    initial begin
        cycle_count = 0;
        while (cycle_count < LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
